//--- verilog.f
+incdir+verif
verilog/spi_pkg.sv
verilog/bus_pkg.sv
verilog/byte_fifo.sv
verilog/spi_core.sv
verilog/spi_regs.sv
verilog/spi_host.sv
verif/tb_spi_host.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_spi_host
FILELIST  := verilog.f
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/tb_spi_tasks.svh
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// 32-bit lcg, numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [7:0] next_byte();
	lcg_state = lcg_next(lcg_state);
	return lcg_state[23:16];
endfunction

// one access, returns 1 ns after the ack edge
task automatic bus_cycle(input logic [BUS_AW-1:0] a, input logic w,
		input logic [BUS_DW-1:0] d, input logic [3:0] be,
		output logic [BUS_DW-1:0] r);
	int n;
	n = 0;
	@(posedge clk);
	#1;
	cs = 1'b1;
	addr = a;
	we = w;
	wdata = d;
	bsel = be;
	do begin
		@(posedge clk);
		#1;
		n++;
	end while (!ack && n < 4);
	r = rdata;
	cs = 1'b0;
	we = 1'b0;
	if (!ack) begin
		err_bus++;
		$display("no ack_o for access to register %0d", a);
	end
endtask

// assertions see the ack cycle before the checks drop
task automatic end_cycle();
	@(posedge clk);
	#1;
	chk_rd = 1'b0;
	chk_cnt = 1'b0;
	exp_evt = 1'b0;
endtask

task automatic write_mode(input logic [BUS_DW-1:0] m, input logic [3:0] be);
	logic [BUS_DW-1:0] r;
	int i;
	bus_cycle(REG_MODE, 1'b1, m, be, r);
	for (i = 0; i < 4; i++) begin
		if (be[i])
			mode_m[8*i +: 8] = m[8*i +: 8];
	end
	outst = 0;  // both buffers cleared
	rx_q.delete();
	end_cycle();
endtask

task automatic write_data(input logic [7:0] b);
	logic [BUS_DW-1:0] r;
	exp_evt = (outst == FIFO_DEPTH);  // dropped when full
	bus_cycle(REG_DATA, 1'b1, {24'd0, b}, 4'hf, r);
	if (outst < FIFO_DEPTH) begin
		outst++;
		rx_q.push_back(b);
	end
	end_cycle();
endtask

task automatic read_check(input logic [BUS_AW-1:0] a, input logic [BUS_DW-1:0] e,
		input logic [BUS_DW-1:0] m, output logic [BUS_DW-1:0] r);
	chk_rd = 1'b1;
	exp_rd = e;
	exp_msk = m;
	bus_cycle(a, 1'b0, '0, 4'hf, r);
	end_cycle();
endtask

`endif

//--- verif/tb_spi_host.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_host import spi_pkg::*, bus_pkg::*; ();

	localparam int N_BYTES = 4;    // per loopback burst
	localparam int MAX_DIV = 3;
	localparam int N_BURSTS = 16;  // 8 modes, 2 dividers
	localparam int WD_CYCLES = N_BURSTS * N_BYTES * 16 * (MAX_DIV + 1) + 3000;

	logic clk = 1'b0;
	logic rst;
	logic cs;
	logic [BUS_AW-1:0] addr;
	logic [3:0] bsel;
	logic we;
	logic [BUS_DW-1:0] wdata;
	wire [BUS_DW-1:0] rdata;
	wire ack;
	wire sck;
	wire mosi;
	wire [15:0] sel_n;
	wire irq;

	spi_mode_t mode_m;          // expected mode register
	int outst;                  // bytes held in both buffers
	logic [7:0] rx_q[$];        // bytes still to come back
	logic [31:0] lcg_state;
	logic chk_rd;
	logic chk_cnt;
	logic exp_evt;              // overflow or underflow due on this access
	logic [BUS_DW-1:0] exp_rd;
	logic [BUS_DW-1:0] exp_msk;
	logic idle;                 // core known to be idle
	logic irq_chk;
	logic rst_q = 1'b0;
	int irq_total = 0;
	int irq_base;
	int exp_irqs;
	int err_bus = 0;
	int err_data = 0;
	int err_irq = 0;

	always #4 clk = ~clk;

	spi_host spi_host_i (
		.clk(clk),
		.rst(rst),
		.cs_i(cs),
		.addr_i(addr),
		.sel_i(bsel),
		.we_i(we),
		.wr_data_i(wdata),
		.rd_data_o(rdata),
		.ack_o(ack),
		.sck_o(sck),
		.mosi_o(mosi),
		.miso_i(mosi),  // loopback
		.sel_n_o(sel_n),
		.irq_o(irq)
	);

	`include "tb_spi_tasks.svh"

	always @(posedge clk) begin
		rst_q <= rst;
		if (!rst && irq)
			irq_total <= irq_total + 1;
	end

	quiet_in_reset: assert property (@(posedge clk) rst && rst_q |-> !ack && !irq)
		else begin
			err_bus++;
			$display("ack_o or irq_o active during reset");
		end
	ack_follows_cs: assert property (@(posedge clk) disable iff (rst) cs && !ack |=> ack)
		else begin
			err_bus++;
			$display("ack_o missing one cycle after cs_i");
		end
	ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
		else begin
			err_bus++;
			$display("ack_o held longer than one cycle");
		end
	read_value: assert property (@(posedge clk) disable iff (rst)
			ack && chk_rd |-> ((rdata ^ exp_rd) & exp_msk) == '0)
		else begin
			err_data++;
			$display("Fail rd_data_o: got %h, expected %h under mask %h",
				$sampled(rdata), $sampled(exp_rd), $sampled(exp_msk));
		end
	rx_count_bound: assert property (@(posedge clk) disable iff (rst)
			ack && chk_cnt |-> int'(rdata[31:16]) <= outst)
		else begin
			err_data++;
			$display("Fail rd_data_o[31:16]: got %h, at most %h",
				$sampled(rdata[31:16]), $sampled(outst));
		end
	sel_pins: assert property (@(posedge clk) disable iff (rst) sel_n == ~mode_m.sel)
		else begin
			err_bus++;
			$display("Fail sel_n_o: got %h, expected %h", $sampled(sel_n), ~$sampled(mode_m.sel));
		end
	sck_idle: assert property (@(posedge clk) disable iff (rst) idle |-> sck == mode_m.cpol)
		else begin
			err_data++;
			$display("Fail sck_o: got %h, expected %h", $sampled(sck), $sampled(mode_m.cpol));
		end
	irq_on_error: assert property (@(posedge clk) disable iff (rst) ack && exp_evt |-> irq)
		else begin
			err_irq++;
			$display("irq_o did not pulse after an overflow or underflow attempt");
		end
	irq_count: assert property (@(posedge clk) disable iff (rst)
			irq_chk |-> irq_total - irq_base == exp_irqs)
		else begin
			err_irq++;
			$display("Fail irq_o pulse count: got %h, expected %h",
				$sampled(irq_total - irq_base), $sampled(exp_irqs));
		end

	// status while disabled, tx holds every byte
	function automatic logic [BUS_DW-1:0] idle_status(input logic ovf, input logic unf);
		spi_status_t s;
		s = '0;
		s.overflow = ovf;
		s.underflow = unf;
		s.full = (outst == FIFO_DEPTH);
		s.tx_empty = (outst == 0);
		return s;
	endfunction

	task automatic read_count(output int rx);
		logic [BUS_DW-1:0] r;
		chk_cnt = 1'b1;
		read_check(REG_COUNT, 32'(FIFO_DEPTH - outst), 32'h0000_ffff, r);
		rx = int'(r[31:16]);
	endtask

	task automatic read_data();
		logic [BUS_DW-1:0] r;
		logic [BUS_DW-1:0] e;
		logic hit;
		hit = (rx_q.size() != 0);
		e = '0;
		exp_evt = ~hit;  // zero and underflow when empty
		if (hit)
			e = {24'd0, rx_q.pop_front()};
		read_check(REG_DATA, e, '1, r);
		if (hit)
			outst--;
	endtask

	task automatic check_irqs(input int n);
		repeat (2) @(posedge clk);
		#1;
		exp_irqs = n;
		irq_chk = 1'b1;
		@(posedge clk);
		#1;
		irq_chk = 1'b0;
	endtask

	task automatic check_mode_access();
		logic [BUS_DW-1:0] m;
		logic [BUS_DW-1:0] r;
		logic [3:0] be;
		int i;
		int k;
		for (k = 0; k < 6; k++) begin
			for (i = 0; i < 4; i++)
				m[8*i +: 8] = next_byte();
			be = 4'(next_byte());
			write_mode(m, be);
			read_check(REG_MODE, mode_m, '1, r);
		end
		write_mode('0, 4'hf);
		read_check(REG_MODE, '0, '1, r);
	endtask

	task automatic check_flags();
		logic [BUS_DW-1:0] r;
		int rx;
		int k;
		write_mode('0, 4'hf);
		for (k = 0; k < FIFO_DEPTH; k++) begin
			write_data(next_byte());
			read_count(rx);
		end
		read_check(REG_STATUS, idle_status(1'b0, 1'b0), '1, r);
		write_data(next_byte());  // no room left
		read_count(rx);
		read_check(REG_STATUS, idle_status(1'b1, 1'b0), '1, r);
		write_mode('0, 4'hf);
		read_check(REG_STATUS, idle_status(1'b0, 1'b0), '1, r);
		read_data();
		read_check(REG_STATUS, idle_status(1'b0, 1'b1), '1, r);
		write_mode('0, 4'hf);
		read_check(REG_STATUS, idle_status(1'b0, 1'b0), '1, r);
		read_count(rx);
	endtask

	task automatic run_loopback(input logic [7:0] div, input logic [2:0] cfg);
		spi_mode_t m;
		spi_status_t s;
		logic [BUS_DW-1:0] r;
		int rx;
		int polls;
		int k;
		m = '0;
		m.sel = 16'h1 << cfg;
		m.baud_div = div;
		m.cpha = cfg[2];
		m.cpol = cfg[1];
		m.lsbfe = cfg[0];
		m.en = 1'b1;
		write_mode(m, 4'hf);
		idle = 1'b0;
		irq_base = irq_total;
		s = '0;
		s.en_act = 1'b1;
		for (k = 0; k < N_BYTES; k++) begin
			write_data(next_byte());
			// first byte still in tx, a transfer outlasts this read
			if (k == 0)
				read_check(REG_STATUS, s, s, r);
		end
		rx = 0;
		polls = 0;
		while (rx != outst && polls < 200) begin
			read_count(rx);
			polls++;
		end
		if (rx != outst) begin
			err_data++;
			$display("loopback bytes did not all return in mode %h", m);
		end
		idle = 1'b1;
		for (k = 0; k < N_BYTES; k++)
			read_data();
		read_count(rx);
		check_irqs(1);  // single tx drain
	endtask

	initial begin
		#(WD_CYCLES * 8);
		$display("timeout: run went past %0d cycles", WD_CYCLES);
		$display("Regression failed");
		$finish;
	end

	initial begin
		int d;
		int c;
		cs = 1'b0;
		addr = '0;
		bsel = '0;
		we = 1'b0;
		wdata = '0;
		rst = 1'b1;
		mode_m = '0;
		outst = 0;
		lcg_state = 32'hc3b8;
		chk_rd = 1'b0;
		chk_cnt = 1'b0;
		exp_evt = 1'b0;
		exp_rd = '0;
		exp_msk = '0;
		idle = 1'b1;
		irq_chk = 1'b0;
		irq_base = 0;
		exp_irqs = 0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		check_mode_access();
		check_flags();
		for (d = 0; d < 2; d++) begin
			for (c = 0; c < 8; c++)
				run_loopback(d == 0 ? 8'd0 : 8'(MAX_DIV), 3'(c));
		end
		repeat (4) @(posedge clk);
		$display("errors: bus %0d, data %0d, irq %0d", err_bus, err_data, err_irq);
		if (err_bus + err_data + err_irq == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/spi_host.sv
`timescale 1ns/1ps
`default_nettype none

module spi_host import spi_pkg::*, bus_pkg::*; (
	input wire clk,
	input wire rst,
	input wire cs_i,
	input wire [BUS_AW-1:0] addr_i,
	input wire [BUS_DW/8-1:0] sel_i,
	input wire we_i,
	input wire [BUS_DW-1:0] wr_data_i,
	output logic [BUS_DW-1:0] rd_data_o,
	output logic ack_o,
	output logic sck_o,
	output logic mosi_o,
	input wire miso_i,
	output logic [15:0] sel_n_o,
	output logic irq_o
);

	spi_mode_t mode;
	logic tx_push;
	logic [BYTE_W-1:0] tx_byte;
	logic rx_pop;
	logic buf_clr;
	fifo_cnt_t tx_count;
	fifo_cnt_t rx_count;
	logic [BYTE_W-1:0] tx_head;
	logic [BYTE_W-1:0] rx_head;
	logic tx_empty;
	logic [BYTE_W-1:0] core_rx_byte;
	logic core_done;      // pops tx and pushes rx together

	assign sel_n_o = ~mode.sel;  // pins are active low

	spi_regs spi_regs_i (
		.clk(clk),
		.rst(rst),
		.cs_i(cs_i),
		.addr_i(addr_i),
		.sel_i(sel_i),
		.we_i(we_i),
		.wr_data_i(wr_data_i),
		.rd_data_o(rd_data_o),
		.ack_o(ack_o),
		.mode_o(mode),
		.tx_count_i(tx_count),
		.rx_count_i(rx_count),
		.rx_byte_i(rx_head),
		.tx_push_o(tx_push),
		.tx_byte_o(tx_byte),
		.rx_pop_o(rx_pop),
		.buf_clr_o(buf_clr),
		.irq_o(irq_o)
	);

	spi_core spi_core_i (
		.clk(clk),
		.rst(rst),
		.mode_i(mode),
		.tx_avail_i(~tx_empty),
		.tx_byte_i(tx_head),
		.rx_byte_o(core_rx_byte),
		.done_o(core_done),
		.sck_o(sck_o),
		.miso_i(miso_i),
		.mosi_o(mosi_o)
	);

	byte_fifo tx_fifo_i (
		.clk(clk),
		.rst(rst),
		.clr_i(buf_clr),
		.push_i(tx_push),
		.data_i(tx_byte),
		.pop_i(core_done),
		.data_o(tx_head),
		.count_o(tx_count),
		.empty_o(tx_empty)
	);

	byte_fifo rx_fifo_i (
		.clk(clk),
		.rst(rst),
		.clr_i(buf_clr),
		.push_i(core_done),
		.data_i(core_rx_byte),
		.pop_i(rx_pop),
		.data_o(rx_head),
		.count_o(rx_count),
		.empty_o()
	);

endmodule

`default_nettype wire

//--- verilog/spi_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_regs import spi_pkg::*, bus_pkg::*; (
	input wire clk,
	input wire rst,
	input wire cs_i,
	input wire [BUS_AW-1:0] addr_i,
	input wire [BUS_DW/8-1:0] sel_i,
	input wire we_i,
	input wire [BUS_DW-1:0] wr_data_i,
	output logic [BUS_DW-1:0] rd_data_o,
	output logic ack_o,
	output spi_mode_t mode_o,
	input wire fifo_cnt_t tx_count_i,
	input wire fifo_cnt_t rx_count_i,
	input wire [BYTE_W-1:0] rx_byte_i,
	output logic tx_push_o,
	output logic [BYTE_W-1:0] tx_byte_o,
	output logic rx_pop_o,
	output logic buf_clr_o,
	output logic irq_o
);

	logic access;
	logic mode_wr;
	logic data_wr;
	logic data_rd;
	logic ovf_flag;
	logic unf_flag;
	logic ovf_evt;
	logic unf_evt;
	logic empty_evt;
	logic tx_empty;
	logic tx_empty_q;
	logic rx_empty;
	logic full;
	fifo_cnt_t used;
	fifo_cnt_t tx_left;
	spi_status_t status;
	logic [BUS_DW-1:0] rd_mux;

	assign access = cs_i & ~ack_o;  // one access per cs cycle
	assign mode_wr = access & we_i & (addr_i == REG_MODE);
	assign data_wr = access & we_i & (addr_i == REG_DATA);
	assign data_rd = access & ~we_i & (addr_i == REG_DATA);

	// tx and rx together form one logical buffer
	assign used = tx_count_i + rx_count_i;
	assign full = (used == fifo_cnt_t'(FIFO_DEPTH));
	assign tx_left = fifo_cnt_t'(FIFO_DEPTH) - used;
	assign tx_empty = (tx_count_i == '0);
	assign rx_empty = (rx_count_i == '0);

	assign ovf_evt = data_wr & full;
	assign unf_evt = data_rd & rx_empty;
	assign empty_evt = tx_empty & ~tx_empty_q;

	always_comb begin
		status = '0;
		status.en_act = mode_o.en & ~tx_empty;
		status.overflow = ovf_flag;
		status.underflow = unf_flag;
		status.full = full;
		status.tx_empty = tx_empty;
	end

	always_comb begin
		case (addr_i)
			REG_STATUS: rd_mux = status;
			REG_COUNT: rd_mux = {(BUS_DW/2)'(rx_count_i), (BUS_DW/2)'(tx_left)};
			REG_MODE: rd_mux = mode_o;
			REG_DATA: rd_mux = rx_empty ? '0 : BUS_DW'(rx_byte_i);  // zero on underflow
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_o <= 1'b0;
			mode_o <= '0;
			tx_push_o <= 1'b0;
			rx_pop_o <= 1'b0;
			buf_clr_o <= 1'b0;
		end else begin
			ack_o <= access;
			tx_push_o <= data_wr & ~full;  // dropped when full
			rx_pop_o <= data_rd & ~rx_empty;
			buf_clr_o <= mode_wr;
			if (mode_wr) begin
				for (int i = 0; i < BUS_DW / 8; i++) begin
					if (sel_i[i])
						mode_o[8*i +: 8] <= wr_data_i[8*i +: 8];
				end
			end
		end
	end

	// rx head is read before the pop lands
	always_ff @(posedge clk) begin
		if (access)
			rd_data_o <= rd_mux;
		if (data_wr)
			tx_byte_o <= wr_data_i[BYTE_W-1:0];  // sel_i ignored here
	end

	// sticky flags, cleared with the buffers
	always_ff @(posedge clk) begin
		if (rst || buf_clr_o) begin
			ovf_flag <= 1'b0;
			unf_flag <= 1'b0;
		end else begin
			if (ovf_evt)
				ovf_flag <= 1'b1;
			if (unf_evt)
				unf_flag <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_empty_q <= 1'b1;
			irq_o <= 1'b0;
		end else begin
			tx_empty_q <= tx_empty;
			irq_o <= ovf_evt | unf_evt | empty_evt;
		end
	end

endmodule

`default_nettype wire

//--- verilog/spi_core.sv
`timescale 1ns/1ps
`default_nettype none

module spi_core import spi_pkg::*; (
	input wire clk,
	input wire rst,
	input wire spi_mode_t mode_i,
	input wire tx_avail_i,
	input wire [BYTE_W-1:0] tx_byte_i,
	output logic [BYTE_W-1:0] rx_byte_o,
	output logic done_o,
	output logic sck_o,
	input wire miso_i,
	output logic mosi_o
);

	logic busy;
	logic [BAUD_W-1:0] div_cnt;
	logic [HALF_W-1:0] half;      // half-bit index within the byte
	logic [BYTE_W-1:0] tx_sr;
	logic sck_q;                  // clock phase before polarity
	logic start;
	logic tick;
	logic last;
	logic sample;
	logic shift;

	// the done cycle is the idle gap, so the popped head has settled
	assign start = ~busy & ~done_o & mode_i.en & tx_avail_i;

	assign tick = busy & (div_cnt == mode_i.baud_div);
	assign last = (half == HALF_W'(2 * BYTE_W - 1));

	// even halves end on a leading edge, odd halves on a trailing edge
	// cpha 0 samples on leading, cpha 1 on trailing
	assign sample = tick & (half[0] == mode_i.cpha);

	// first bit is already on mosi from the load
	assign shift = tick & (half[0] != mode_i.cpha) & (half != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			div_cnt <= '0;
			half <= '0;
			sck_q <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= tick & last;

			if (start) begin
				busy <= 1'b1;
				div_cnt <= '0;
				half <= '0;
			end else if (tick) begin
				div_cnt <= '0;
				sck_q <= ~sck_q;  // 16 toggles, ends back at idle
				half <= half + 1'b1;
				if (last)
					busy <= 1'b0;
			end else if (busy) begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// shift registers
	always_ff @(posedge clk) begin
		if (start)
			tx_sr <= tx_byte_i;
		else if (shift)
			tx_sr <= mode_i.lsbfe ? (tx_sr >> 1) : (tx_sr << 1);

		if (sample) begin
			if (mode_i.lsbfe)
				rx_byte_o <= {miso_i, rx_byte_o[BYTE_W-1:1]};
			else
				rx_byte_o <= {rx_byte_o[BYTE_W-2:0], miso_i};
		end
	end

	assign mosi_o = mode_i.lsbfe ? tx_sr[0] : tx_sr[BYTE_W-1];
	assign sck_o = sck_q ^ mode_i.cpol;  // idles at cpol

endmodule

`default_nettype wire

//--- verilog/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo import spi_pkg::*; (
	input wire clk,
	input wire rst,
	input wire clr_i,
	input wire push_i,
	input wire [BYTE_W-1:0] data_i,
	input wire pop_i,
	output logic [BYTE_W-1:0] data_o,
	output fifo_cnt_t count_o,
	output logic empty_o
);

	logic [BYTE_W-1:0] mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic full;
	logic do_push;
	logic do_pop;

	assign empty_o = (count_o == '0);
	assign full = (count_o == fifo_cnt_t'(FIFO_DEPTH));

	// a pop frees a slot for a push in the same cycle
	assign do_pop = pop_i & ~empty_o;
	assign do_push = push_i & (~full | do_pop);

	assign data_o = mem[rd_ptr];  // show-ahead head

	always_ff @(posedge clk) begin
		if (rst || clr_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count_o <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({do_push, do_pop})
				2'b10: count_o <= count_o + 1'b1;
				2'b01: count_o <= count_o - 1'b1;
				default: count_o <= count_o;  // idle or both
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

endmodule

`default_nettype wire

//--- verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

	localparam int BUS_AW = 2;  // word address
	localparam int BUS_DW = 32;

	// register map
	localparam logic [BUS_AW-1:0] REG_STATUS = 2'd0;
	localparam logic [BUS_AW-1:0] REG_COUNT = 2'd1;
	localparam logic [BUS_AW-1:0] REG_MODE = 2'd2;
	localparam logic [BUS_AW-1:0] REG_DATA = 2'd3;

	// status word, read only
	typedef struct packed {
		logic en_act;          // enabled and tx data pending
		logic [26:0] reserved;
		logic overflow;
		logic underflow;
		logic full;
		logic tx_empty;
	} spi_status_t;

endpackage

`default_nettype wire

//--- verilog/spi_pkg.sv
`default_nettype none

package spi_pkg;

	localparam int BYTE_W = 8;
	localparam int BAUD_W = 8;

	// both buffers share this sizing
	localparam int FIFO_AW = 4;
	localparam int FIFO_DEPTH = 16;

	// half-bit counter width in the shift engine
	localparam int HALF_W = $clog2(2 * BYTE_W);

	// 0..FIFO_DEPTH, so one bit wider than the pointers
	typedef logic [FIFO_AW:0] fifo_cnt_t;

	// mode register layout, msb first
	typedef struct packed {
		logic [15:0] sel;          // slave selects, active high here
		logic [BAUD_W-1:0] baud_div; // half-bit period minus one
		logic cpha;
		logic cpol;
		logic lsbfe;               // lsb first when set
		logic [3:0] reserved;
		logic en;
	} spi_mode_t;

endpackage

`default_nettype wire
